//--- wb_defines.svh
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// ############################
// Architectural widths of the writeback stage
// ############################

`define WB_DATA_W  32    // Data word and address width
`define WB_REG_AW  5     // General register index width
`define WB_ECODE_W 6
`define WB_ESUB_W  9

// Number of general registers including r0
`define WB_NREGS   (1 << `WB_REG_AW)

`endif

//--- wb_types_pkg.sv
`include "wb_defines.svh"

package wb_types_pkg;

    // One-hot load kind with LB in bit 0 and all zero for a non-load
    typedef struct packed {
        logic lhu;
        logic lbu;
        logic lw;
        logic lh;
        logic lb;
    } ld_op_t;

    // One SRAM word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } ld_word_u;

    // Everything the memory stage hands over for one instruction
    typedef struct packed {
        logic [`WB_DATA_W-1:0]  pc;
        logic [`WB_DATA_W-1:0]  result;     // Also serves as the load address
        logic [`WB_DATA_W-1:0]  rdata;      // Raw SRAM word for loads
        ld_op_t                 ld_op;
        logic                   gr_we;
        logic [`WB_REG_AW-1:0]  dest;
        logic                   has_exc;
        logic [`WB_ECODE_W-1:0] ecode;
        logic [`WB_ESUB_W-1:0]  esubcode;
        logic [`WB_DATA_W-1:0]  maddr;      // Faulting address for address errors
        logic                   ertn;
    } wb_payload_t;

endpackage

//--- wb_exc_pkg.sv
`include "wb_defines.svh"

package wb_exc_pkg;

    // ############################
    // Exception codes seen at writeback
    // ############################

    localparam logic [`WB_ECODE_W-1:0] ECODE_ADEF = 6'h08;  // Fetch address error
    localparam logic [`WB_ECODE_W-1:0] ECODE_ALE  = 6'h09;  // Misaligned data access
    localparam logic [`WB_ECODE_W-1:0] ECODE_SYS  = 6'h0b;
    localparam logic [`WB_ECODE_W-1:0] ECODE_BRK  = 6'h0c;
    localparam logic [`WB_ECODE_W-1:0] ECODE_INE  = 6'h0d;  // Instruction not defined

    // What the CSR side needs to take one exception
    typedef struct packed {
        logic [`WB_ECODE_W-1:0] ecode;
        logic [`WB_ESUB_W-1:0]  esubcode;
        logic [`WB_DATA_W-1:0]  pc;
        logic [`WB_DATA_W-1:0]  maddr;
    } exc_rec_t;

endpackage

//--- wb_ifs.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

// Register file write side plus the two decode read ports
interface wb_rf_if ();
    logic                  we;
    logic [`WB_REG_AW-1:0] waddr;
    logic [`WB_DATA_W-1:0] wdata;
    logic [`WB_REG_AW-1:0] raddr1;
    logic [`WB_REG_AW-1:0] raddr2;
    logic [`WB_DATA_W-1:0] rdata1;
    logic [`WB_DATA_W-1:0] rdata2;

    modport wr (output we, waddr, wdata);
    modport rf (input we, waddr, wdata, raddr1, raddr2, output rdata1, rdata2);
endinterface

// Load word and kind out to the aligner and the extended value back
interface wb_ld_if import wb_types_pkg::*; (input logic clk);
    logic [`WB_DATA_W-1:0] rdata;
    logic [1:0]            addr_lo;
    ld_op_t                ld_op;
    logic [`WB_DATA_W-1:0] ld_data;

    modport ctrl  (output rdata, addr_lo, ld_op, input ld_data);
    modport align (input clk, rdata, addr_lo, ld_op, output ld_data);
endinterface

interface wb_exc_if import wb_exc_pkg::*; ();
    logic     valid;    // Exception commit
    logic     ertn;     // Exception return commit
    exc_rec_t rec;

    modport ctrl   (output valid, ertn, rec);
    modport commit (input valid, ertn, rec);
endinterface

//--- wb_ctrl.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_ctrl import wb_types_pkg::*; import wb_exc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  wb_payload_t           in_payload,
    wb_ld_if.ctrl                 ld,
    wb_rf_if.wr                   rf,
    wb_exc_if.ctrl                exc,
    output logic [`WB_DATA_W-1:0] debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [`WB_REG_AW-1:0] debug_wb_rf_wnum,
    output logic [`WB_DATA_W-1:0] debug_wb_rf_wdata
);

    logic        valid_q;
    wb_payload_t pl_q;
    logic        accept;
    logic        flush;

    // ############################
    // Stage register and handshake
    // ############################

    // The stage always finishes in one cycle so it only stalls in reset
    assign in_ready = rst_n;
    assign accept   = in_valid & in_ready;

    // A committing exception or ertn kills whatever arrives behind it
    assign flush = exc.valid | exc.ertn;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pl_q <= in_payload;
        end
    end

    // ############################
    // Steering
    // ############################

    assign ld.rdata   = pl_q.rdata;
    assign ld.addr_lo = pl_q.result[1:0];
    assign ld.ld_op   = valid_q ? pl_q.ld_op : '0;     // Aligner idles between items

    assign rf.we    = valid_q & pl_q.gr_we & ~pl_q.has_exc & ~pl_q.ertn;
    assign rf.waddr = pl_q.dest;
    assign rf.wdata = (|pl_q.ld_op) ? ld.ld_data : pl_q.result;

    assign exc.valid = valid_q & pl_q.has_exc;
    assign exc.ertn  = valid_q & pl_q.ertn;
    assign exc.rec   = exc_rec_t'{ecode:    pl_q.ecode,
                                  esubcode: pl_q.esubcode,
                                  pc:       pl_q.pc,
                                  maddr:    pl_q.maddr};

    // Trace port for the reference model comparison
    assign debug_wb_pc       = pl_q.pc;
    assign debug_wb_rf_we    = {4{rf.we}};
    assign debug_wb_rf_wnum  = rf.waddr;
    assign debug_wb_rf_wdata = rf.wdata;

    // Upstream never marks one instruction as both trap and return
    a_exc_ertn_excl: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> !(in_payload.has_exc && in_payload.ertn));

    a_we_exc_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rf.we && exc.valid));

endmodule

//--- wb_load_align.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_load_align import wb_types_pkg::*; (
    wb_ld_if.align ld
);

    ld_word_u    word;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // ############################
    // Lane selection
    // ############################

    assign word      = ld.rdata;
    assign byte_lane = word.bytes[ld.addr_lo];       // Little endian byte order
    assign half_lane = word.halves[ld.addr_lo[1]];

    // ############################
    // Extension
    // ############################

    always_comb begin
        if (ld.ld_op.lb) begin
            ld.ld_data = {{24{byte_lane[7]}}, byte_lane};
        end else if (ld.ld_op.lbu) begin
            ld.ld_data = {24'd0, byte_lane};
        end else if (ld.ld_op.lh) begin
            ld.ld_data = {{16{half_lane[15]}}, half_lane};
        end else if (ld.ld_op.lhu) begin
            ld.ld_data = {16'd0, half_lane};
        end else if (ld.ld_op.lw) begin
            ld.ld_data = word;                       // Word loads pass straight through
        end else begin
            ld.ld_data = '0;
        end
    end

    // Decode upstream gives at most one load kind per item
    a_ld_op_onehot: assert property (@(posedge ld.clk)
        $onehot0(ld.ld_op));

    // Misaligned halfwords must have trapped as ALE in the memory stage
    a_half_aligned: assert property (@(posedge ld.clk)
        (ld.ld_op.lh || ld.ld_op.lhu) |-> !ld.addr_lo[0]);

endmodule

//--- wb_regfile.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_regfile (
    input  logic clk,
    input  logic rst_n,
    wb_rf_if.rf  rf
);

    // r0 has no storage
    logic [`WB_DATA_W-1:0] regs [1:`WB_NREGS-1];

    // ############################
    // Write port
    // ############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `WB_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.we && (rf.waddr != '0)) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // Reads see the old value during a same-cycle write
    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

    a_waddr_known: assert property (@(posedge clk) disable iff (!rst_n)
        rf.we |-> !$isunknown(rf.waddr));

endmodule

//--- wb_exc_commit.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_exc_commit import wb_exc_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    wb_exc_if.commit               exc,
    output logic                   exception_submit,
    output logic [`WB_ECODE_W-1:0] ecode_submit,
    output logic [`WB_ESUB_W-1:0]  esubcode_submit,
    output logic [`WB_DATA_W-1:0]  exception_pc_submit,
    output logic [`WB_DATA_W-1:0]  exception_maddr_submit,
    output logic                   ertn_submit,
    output logic [`WB_DATA_W-1:0]  era,
    output logic [`WB_DATA_W-1:0]  badv
);

    logic addr_fault;

    // Submit side goes straight to the CSR unit
    assign exception_submit       = exc.valid;
    assign ecode_submit           = exc.rec.ecode;
    assign esubcode_submit        = exc.rec.esubcode;
    assign exception_pc_submit    = exc.rec.pc;
    assign exception_maddr_submit = exc.rec.maddr;
    assign ertn_submit            = exc.ertn;

    // Only address errors carry a meaningful bad address
    assign addr_fault = (exc.rec.ecode == ECODE_ADEF) || (exc.rec.ecode == ECODE_ALE);

    // ############################
    // Last exception record
    // ############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            era  <= '0;
            badv <= '0;
        end else if (exc.valid) begin
            era <= exc.rec.pc;
            if (addr_fault) begin
                badv <= exc.rec.maddr;
            end
        end
    end

endmodule

//--- wb_top.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_top import wb_types_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`WB_DATA_W-1:0]  in_pc,
    input  logic [`WB_DATA_W-1:0]  in_result,
    input  logic [`WB_DATA_W-1:0]  data_sram_rdata,
    input  logic [4:0]             mem_op,          // LB LH LW LBU LHU from bit 0 up
    input  logic                   gr_we,
    input  logic [`WB_REG_AW-1:0]  dest,
    input  logic                   has_exception,
    input  logic [`WB_ECODE_W-1:0] ecode,
    input  logic [`WB_ESUB_W-1:0]  esubcode,
    input  logic [`WB_DATA_W-1:0]  exception_maddr,
    input  logic                   ertn,
    input  logic [`WB_REG_AW-1:0]  raddr1,
    input  logic [`WB_REG_AW-1:0]  raddr2,
    output logic [`WB_DATA_W-1:0]  rdata1,
    output logic [`WB_DATA_W-1:0]  rdata2,
    output logic [`WB_DATA_W-1:0]  debug_wb_pc,
    output logic [3:0]             debug_wb_rf_we,
    output logic [`WB_REG_AW-1:0]  debug_wb_rf_wnum,
    output logic [`WB_DATA_W-1:0]  debug_wb_rf_wdata,
    output logic                   exception_submit,
    output logic [`WB_ECODE_W-1:0] ecode_submit,
    output logic [`WB_ESUB_W-1:0]  esubcode_submit,
    output logic [`WB_DATA_W-1:0]  exception_pc_submit,
    output logic [`WB_DATA_W-1:0]  exception_maddr_submit,
    output logic                   ertn_submit,
    output logic [`WB_DATA_W-1:0]  era,
    output logic [`WB_DATA_W-1:0]  badv
);

    wb_payload_t in_payload;

    wb_ld_if  u_ld_if (.clk(clk));
    wb_rf_if  u_rf_if ();
    wb_exc_if u_exc_if ();

    // ############################
    // Port bundling
    // ############################

    assign in_payload.pc       = in_pc;
    assign in_payload.result   = in_result;
    assign in_payload.rdata    = data_sram_rdata;
    assign in_payload.ld_op    = mem_op;
    assign in_payload.gr_we    = gr_we;
    assign in_payload.dest     = dest;
    assign in_payload.has_exc  = has_exception;
    assign in_payload.ecode    = ecode;
    assign in_payload.esubcode = esubcode;
    assign in_payload.maddr    = exception_maddr;
    assign in_payload.ertn     = ertn;

    // Decode read ports
    assign u_rf_if.raddr1 = raddr1;
    assign u_rf_if.raddr2 = raddr2;
    assign rdata1         = u_rf_if.rdata1;
    assign rdata2         = u_rf_if.rdata2;

    wb_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .in_payload        (in_payload),
        .ld                (u_ld_if.ctrl),
        .rf                (u_rf_if.wr),
        .exc               (u_exc_if.ctrl),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    wb_load_align u_load_align (
        .ld (u_ld_if.align)
    );

    wb_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (u_rf_if.rf)
    );

    wb_exc_commit u_exc_commit (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .exc                    (u_exc_if.commit),
        .exception_submit       (exception_submit),
        .ecode_submit           (ecode_submit),
        .esubcode_submit        (esubcode_submit),
        .exception_pc_submit    (exception_pc_submit),
        .exception_maddr_submit (exception_maddr_submit),
        .ertn_submit            (ertn_submit),
        .era                    (era),
        .badv                   (badv)
    );

endmodule

//--- tb_wb_top.sv
`timescale 1ns/1ps
`include "wb_defines.svh"

module tb_wb_top import wb_exc_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int SWEEP_ROUNDS = 4;
    localparam int N_SWEEP      = SWEEP_ROUNDS * 14;
    localparam int N_RAND       = 300;
    localparam int N_DIRECTED   = 8;
    localparam int N_ITEMS      = N_SWEEP + N_RAND + N_DIRECTED;

    // Load kinds with LB in bit 0
    localparam logic [4:0] OP_LB  = 5'b00001;
    localparam logic [4:0] OP_LH  = 5'b00010;
    localparam logic [4:0] OP_LW  = 5'b00100;
    localparam logic [4:0] OP_LBU = 5'b01000;
    localparam logic [4:0] OP_LHU = 5'b10000;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic                   in_ready;
    logic [`WB_DATA_W-1:0]  in_pc, in_result, data_sram_rdata, exception_maddr;
    logic [4:0]             mem_op;
    logic                   gr_we, has_exception, ertn;
    logic [`WB_REG_AW-1:0]  dest, raddr1, raddr2;
    logic [`WB_ECODE_W-1:0] ecode;
    logic [`WB_ESUB_W-1:0]  esubcode;
    logic [`WB_DATA_W-1:0]  rdata1, rdata2, debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]             debug_wb_rf_we;
    logic [`WB_REG_AW-1:0]  debug_wb_rf_wnum;
    logic                   exception_submit, ertn_submit;
    logic [`WB_ECODE_W-1:0] ecode_submit;
    logic [`WB_ESUB_W-1:0]  esubcode_submit;
    logic [`WB_DATA_W-1:0]  exception_pc_submit, exception_maddr_submit, era, badv;

    int          seed;
    int          errors;
    int          items;
    logic [4:0]  last_dest, older_dest;

    // Reference model state
    logic        p_valid;
    logic [31:0] p_pc, p_result, p_rdata, p_maddr;
    logic [4:0]  p_op, p_dest;
    logic        p_gr_we, p_exc, p_ertn;
    logic [5:0]  p_ecode;
    logic [8:0]  p_esub;
    logic [31:0] shadow [0:31];
    logic [31:0] m_era, m_badv;
    logic        exp_we, exp_exc, exp_ertn;
    logic [31:0] exp_wdata;

    wb_top u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Byte offset picks the lane, the kind picks the extension
    function automatic logic [31:0] expect_wdata(input logic [4:0] op, input logic [31:0] word,
                                                 input logic [31:0] result);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> {result[1:0], 3'b000});
        h = 16'(word >> {result[1], 4'b0000});
        case (op)
            OP_LB:   expect_wdata = {{24{b[7]}}, b};
            OP_LH:   expect_wdata = {{16{h[15]}}, h};
            OP_LW:   expect_wdata = word;
            OP_LBU:  expect_wdata = {24'd0, b};
            OP_LHU:  expect_wdata = {16'd0, h};
            default: expect_wdata = result;
        endcase
    endfunction

    assign exp_we    = p_valid && p_gr_we && !p_exc && !p_ertn;
    assign exp_exc   = p_valid && p_exc;
    assign exp_ertn  = p_valid && p_ertn;
    assign exp_wdata = expect_wdata(p_op, p_rdata, p_result);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p_valid <= 1'b0;
            m_era   <= '0;
            m_badv  <= '0;
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (exp_we && p_dest != 5'd0) begin
                shadow[p_dest] <= exp_wdata;
            end
            if (exp_exc) begin
                m_era <= p_pc;
                if (p_ecode == ECODE_ADEF || p_ecode == ECODE_ALE) begin
                    m_badv <= p_maddr;
                end
            end
            p_valid  <= in_valid && !(exp_exc || exp_ertn);   // Flushed behind a commit
            p_pc     <= in_pc;
            p_result <= in_result;
            p_rdata  <= data_sram_rdata;
            p_op     <= mem_op;
            p_gr_we  <= gr_we;
            p_dest   <= dest;
            p_exc    <= has_exception;
            p_ecode  <= ecode;
            p_esub   <= esubcode;
            p_maddr  <= exception_maddr;
            p_ertn   <= ertn;
        end
    end

    // ############################
    // Checks
    // ############################

    task automatic note_mismatch(input string what);
        errors = errors + 1;
        $display("Fail at %0t ns: %s", $time, what);
    endtask

    a_reset_quiet: assert property (@(negedge clk) !rst_n |->
        (!in_ready && debug_wb_rf_we == 4'd0 && !exception_submit && !ertn_submit))
        else note_mismatch("handshake or commit outputs active during reset");
    a_ready: assert property (@(negedge clk) rst_n |-> in_ready)
        else note_mismatch("in_ready low outside reset");
    a_wr_enable: assert property (@(negedge clk) disable iff (!rst_n)
        debug_wb_rf_we == {4{exp_we}})
        else note_mismatch($sformatf("debug_wb_rf_we %h, expected %h", debug_wb_rf_we,
                                     {4{exp_we}}));
    a_wr_data: assert property (@(negedge clk) disable iff (!rst_n)
        p_valid |-> (debug_wb_rf_wdata == exp_wdata && debug_wb_pc == p_pc))
        else note_mismatch($sformatf("wdata %h pc %h, expected %h pc %h", debug_wb_rf_wdata,
                                     debug_wb_pc, exp_wdata, p_pc));
    a_wr_num: assert property (@(negedge clk) disable iff (!rst_n)
        exp_we |-> debug_wb_rf_wnum == p_dest)
        else note_mismatch($sformatf("wnum %0d, expected %0d", debug_wb_rf_wnum, p_dest));
    a_exc_flag: assert property (@(negedge clk) disable iff (!rst_n)
        exception_submit == exp_exc)
        else note_mismatch($sformatf("exception_submit %b, expected %b", exception_submit,
                                     exp_exc));
    a_exc_rec: assert property (@(negedge clk) disable iff (!rst_n)
        exp_exc |-> (ecode_submit == p_ecode && esubcode_submit == p_esub &&
                     exception_pc_submit == p_pc && exception_maddr_submit == p_maddr))
        else note_mismatch($sformatf("exception record %h %h %h %h, expected %h %h %h %h",
            ecode_submit, esubcode_submit, exception_pc_submit, exception_maddr_submit,
            p_ecode, p_esub, p_pc, p_maddr));
    a_ertn: assert property (@(negedge clk) disable iff (!rst_n) ertn_submit == exp_ertn)
        else note_mismatch($sformatf("ertn_submit %b, expected %b", ertn_submit, exp_ertn));
    a_era_badv: assert property (@(negedge clk) disable iff (!rst_n)
        era == m_era && badv == m_badv)
        else note_mismatch($sformatf("era %h badv %h, expected %h %h", era, badv,
                                     m_era, m_badv));
    a_read_ports: assert property (@(negedge clk) disable iff (!rst_n)
        rdata1 == shadow[raddr1] && rdata2 == shadow[raddr2])
        else note_mismatch($sformatf("r%0d reads %h, r%0d reads %h, expected %h %h", raddr1,
            rdata1, raddr2, rdata2, shadow[raddr1], shadow[raddr2]));
    a_r0_zero: assert property (@(negedge clk)
        (raddr1 != 5'd0 || rdata1 == '0) && (raddr2 != 5'd0 || rdata2 == '0))
        else note_mismatch("r0 reads nonzero");

    // ############################
    // Stimulus
    // ############################

    task automatic fill_random();
        in_pc           = $random(seed);
        in_result       = $random(seed);
        data_sram_rdata = $random(seed);
        exception_maddr = $random(seed);
        esubcode        = 9'($random(seed));
        ecode           = 6'($random(seed));
        dest            = 5'($random(seed));
        raddr2          = 5'($random(seed));
        mem_op          = '0;
        gr_we           = 1'b0;
        has_exception   = 1'b0;
        ertn            = 1'b0;
    endtask

    // Holds the item until the stage takes it, reading back two items behind
    task automatic offer();
        in_valid = 1'b1;
        raddr1   = older_dest;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        #1;
        older_dest = last_dest;
        last_dest  = dest;
        items      = items + 1;
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_alu(input logic we);
        fill_random();
        gr_we = we;
        offer();
    endtask

    task automatic send_load(input logic [4:0] op, input logic [1:0] lo);
        fill_random();
        mem_op    = op;
        in_result = {in_result[31:2], lo};
        gr_we     = 1'b1;
        offer();
    endtask

    task automatic send_exc(input logic [5:0] code);
        fill_random();
        has_exception = 1'b1;
        ecode         = code;
        gr_we         = 1'($random(seed));     // Must be ignored
        offer();
    endtask

    task automatic send_ertn();
        fill_random();
        ertn  = 1'b1;
        gr_we = 1'($random(seed));
        offer();
    endtask

    task automatic send_random_load();
        logic [2:0] k;
        logic [1:0] lo;
        k  = 3'($random(seed));
        lo = 2'($random(seed));
        case (k)
            3'd0, 3'd5: send_load(OP_LB, lo);
            3'd1, 3'd6: send_load(OP_LBU, lo);
            3'd2:       send_load(OP_LH, {lo[1], 1'b0});
            3'd3:       send_load(OP_LHU, {lo[1], 1'b0});
            default:    send_load(OP_LW, 2'd0);
        endcase
    endtask

    task automatic send_random_exc();
        logic [2:0] k;
        k = 3'($random(seed));
        case (k)
            3'd0:       send_exc(ECODE_ADEF);
            3'd1, 3'd5: send_exc(ECODE_ALE);
            3'd2:       send_exc(ECODE_SYS);
            3'd3:       send_exc(ECODE_BRK);
            3'd4:       send_exc(ECODE_INE);
            default:    send_exc(6'($random(seed)));
        endcase
    endtask

    initial begin
        logic [2:0] kind;
        seed       = 32'haa654cb8;
        errors     = 0;
        items      = 0;
        last_dest  = '0;
        older_dest = '0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        raddr1     = '0;
        fill_random();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int r = 0; r < SWEEP_ROUNDS; r++) begin
            for (int lo = 0; lo < 4; lo++) begin
                send_load(OP_LB, 2'(lo));
                send_load(OP_LBU, 2'(lo));
            end
            send_load(OP_LH, 2'd0);
            send_load(OP_LH, 2'd2);
            send_load(OP_LHU, 2'd0);
            send_load(OP_LHU, 2'd2);
            send_load(OP_LW, 2'd0);
            send_alu(1'b1);
        end

        // Back-to-back mix, so every commit is followed by an item to flush
        for (int i = 0; i < N_RAND; i++) begin
            kind = 3'($random(seed));
            case (kind)
                3'd0, 3'd1, 3'd2: send_alu(1'b1);
                3'd3:             send_alu(1'b0);
                3'd4, 3'd5:       send_random_load();
                3'd6:             send_random_exc();
                default:          send_ertn();
            endcase
            if (kind == 3'd3) begin
                idle(1);
            end
        end

        fill_random();
        gr_we     = 1'b1;
        dest      = 5'd0;
        in_result = 32'hffff_ffff;
        offer();
        fill_random();
        gr_we     = 1'b1;
        dest      = 5'd7;
        in_result = 32'h1234_5678;
        offer();
        send_exc(ECODE_SYS);
        fill_random();
        gr_we     = 1'b1;
        dest      = 5'd7;                       // Flushed behind the exception
        in_result = 32'hdead_beef;
        offer();
        send_ertn();
        fill_random();
        gr_we     = 1'b1;
        dest      = 5'd7;
        in_result = 32'hbad0_0bad;
        offer();
        send_alu(1'b1);
        send_alu(1'b1);
        raddr1 = 5'd7;
        raddr2 = 5'd0;
        idle(3);

        $display("Summary: %0d items accepted, %0d errors", items, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Idle gaps and reset are covered by the margin
    initial begin
        #(N_ITEMS * CLK_PERIOD + (N_RAND + RESET_CYCLES + 50) * CLK_PERIOD);
        $display("Timeout: the stimulus did not complete within the expected time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
wb_types_pkg.sv
wb_exc_pkg.sv
wb_ifs.sv
wb_ctrl.sv
wb_load_align.sv
wb_regfile.sv
wb_exc_commit.sv
wb_top.sv
tb_wb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the writeback stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timescale 1ns/1ps -f vlog.f --top-module tb_wb_top \
    --Mdir "$OBJ" -o sim_wb_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_wb_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
exit 0
